// ==== state_valid_top.f ====
common/state_pkg.sv
db_core/db_core.sv
hw/state_ram.sv
hw/state_valid_core.sv
hw/state_valid_top.sv
test/state_valid_checker.sv
test/state_valid_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the state table testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module state_valid_tb \
    -f state_valid_top.f -o state_valid_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/state_valid_sim +verilator+error+limit+10 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    exit 0
fi
exit 1

// ==== test/state_valid_tb.sv ====
`timescale 1ns/1ns

module state_valid_tb import state_pkg::*; ();

    localparam int CLK_HALF = 4;
    localparam int RESET_CYCLES = 4;
    localparam int TABLE_LEN = 25;
    localparam int N_RAND = 64;
    localparam int N_SETS = 6;
    // Budget covers the table steps, two sweeps with slack and the random burst
    localparam int WATCHDOG_CYCLES = TABLE_LEN * 10 + 3 * NUM_IDS + N_RAND * 4;

    // Step opcodes are the control commands plus an update read
    localparam logic [2:0] OP_SET = {1'b0, COMMAND_SET};
    localparam logic [2:0] OP_UNSET = {1'b0, COMMAND_UNSET};
    localparam logic [2:0] OP_GET = {1'b0, COMMAND_GET};
    localparam logic [2:0] OP_CLEAR = {1'b0, COMMAND_CLEAR};
    localparam logic [2:0] OP_READ = 3'd4;

    typedef struct packed {
        logic [2:0]      op;
        logic [ID_W-1:0] id;
        logic            exp;
    } step_t;

    // Op, ID, expected bit (old bit for SET/UNSET)
    step_t steps [TABLE_LEN] = '{
        // Fresh table reads 0
        {OP_GET, 8'd5, 1'b0}, {OP_GET, 8'd200, 1'b0}, {OP_READ, 8'd5, 1'b0},
        {OP_READ, 8'd255, 1'b0}, {OP_READ, 8'd0, 1'b0},
        // SET
        {OP_SET, 8'd5, 1'b0}, {OP_GET, 8'd5, 1'b1}, {OP_READ, 8'd5, 1'b1},
        {OP_READ, 8'd6, 1'b0}, {OP_SET, 8'd5, 1'b1},
        // UNSET twice
        {OP_UNSET, 8'd5, 1'b1}, {OP_UNSET, 8'd5, 1'b0}, {OP_GET, 8'd5, 1'b0},
        {OP_READ, 8'd5, 1'b0},
        // CLEAR after several SETs
        {OP_SET, 8'd10, 1'b0}, {OP_SET, 8'd77, 1'b0}, {OP_SET, 8'd255, 1'b0},
        {OP_SET, 8'd0, 1'b0}, {OP_READ, 8'd77, 1'b1}, {OP_GET, 8'd255, 1'b1},
        {OP_CLEAR, 8'd0, 1'b0}, {OP_GET, 8'd10, 1'b0}, {OP_READ, 8'd77, 1'b0},
        {OP_READ, 8'd255, 1'b0}, {OP_GET, 8'd0, 1'b0}
    };

    logic             clk;
    logic             reset;
    logic             init_done;
    logic             ctrl_req;
    logic [CMD_W-1:0] ctrl_command;
    logic [ID_W-1:0]  ctrl_id;
    logic             ctrl_rdy;
    logic             ctrl_ack;
    logic             ctrl_state;
    logic             update_req;
    logic [ID_W-1:0]  update_id;
    logic             update_rdy;
    logic             update_ack;
    logic             update_state;
    logic             evt_activate;
    logic             evt_deactivate;

    // Reference model of the table
    logic model [NUM_IDS];
    int   seed = 86091;

    state_valid_top state_valid_top_inst (
        .clk            (clk),
        .reset          (reset),
        .init_done      (init_done),
        .ctrl_req       (ctrl_req),
        .ctrl_command   (ctrl_command),
        .ctrl_id        (ctrl_id),
        .ctrl_rdy       (ctrl_rdy),
        .ctrl_ack       (ctrl_ack),
        .ctrl_state     (ctrl_state),
        .update_req     (update_req),
        .update_id      (update_id),
        .update_rdy     (update_rdy),
        .update_ack     (update_ack),
        .update_state   (update_state),
        .evt_activate   (evt_activate),
        .evt_deactivate (evt_deactivate)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    // Protocol assertions fire in the bound checker
    always @(negedge clk) begin
        if (state_valid_top_inst.state_valid_checker_inst.fail_count != 0) begin
            fail_now("protocol assertion failed in the checker");
        end
    end

    task automatic fail_now(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic clear_model();
        foreach (model[i]) begin
            model[i] = 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // Port drivers drive on the rising edge and sample on the falling edge
    // ------------------------------------------------------------

    task automatic send_command(input logic [CMD_W-1:0] cmd, input logic [ID_W-1:0] id,
                                output logic state, output int n_act, output int n_deact,
                                output logic saw_init_low);
        @(posedge clk);
        ctrl_req <= 1'b1;
        ctrl_command <= cmd;
        ctrl_id <= id;
        @(negedge clk);
        while (!ctrl_rdy) @(negedge clk);
        // Accepted on this edge
        @(posedge clk);
        ctrl_req <= 1'b0;
        n_act = 0;
        n_deact = 0;
        saw_init_low = 1'b0;
        do begin
            @(negedge clk);
            if (evt_activate) n_act++;
            if (evt_deactivate) n_deact++;
            if (!init_done) saw_init_low = 1'b1;
        end while (!ctrl_ack);
        state = ctrl_state;
    endtask

    task automatic read_update(input logic [ID_W-1:0] id, output logic state);
        int cycles;
        @(posedge clk);
        update_req <= 1'b1;
        update_id <= id;
        @(negedge clk);
        while (!update_rdy) @(negedge clk);
        @(posedge clk);
        update_req <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!update_ack);
        assert (cycles == RD_LATENCY)
        else fail_now($sformatf("update_ack after %0d cycles, expected %0d", cycles, RD_LATENCY));
        state = update_state;
    endtask

    task automatic apply_step(input step_t s);
        logic resp;
        logic model_exp;
        int   n_act;
        int   n_deact;
        logic saw_low;
        // GET and reads give the stored bit while SET/UNSET give the old one
        model_exp = (s.op == OP_CLEAR) ? 1'b0 : model[s.id];
        if (s.op == OP_READ) begin
            read_update(s.id, resp);
        end else begin
            send_command(s.op[CMD_W-1:0], s.id, resp, n_act, n_deact, saw_low);
        end
        assert (resp === s.exp && resp === model_exp)
        else fail_now($sformatf("op %0d id %0d returned %b, table %b, model %b",
                                s.op, s.id, resp, s.exp, model_exp));
        // Event pulses are counted on control commands only
        if (s.op != OP_READ) begin
            assert (n_act == ((s.op == OP_SET) ? 1 : 0))
            else fail_now($sformatf("op %0d saw %0d evt_activate pulses", s.op, n_act));
            assert (n_deact == ((s.op == OP_UNSET) ? 1 : 0))
            else fail_now($sformatf("op %0d saw %0d evt_deactivate pulses", s.op, n_deact));
        end
        if (s.op == OP_CLEAR) begin
            assert (saw_low) else fail_now("init_done did not drop during CLEAR");
            clear_model();
        end else if (s.op == OP_SET) begin
            model[s.id] = 1'b1;
        end else if (s.op == OP_UNSET) begin
            model[s.id] = 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // Back-to-back update reads with SETs in flight
    // ------------------------------------------------------------

    task automatic random_burst();
        logic [ID_W-1:0] rd_ids [N_RAND];
        logic [ID_W-1:0] set_ids [N_SETS];
        int              gaps [N_SETS];
        logic            pending [$];
        logic [ID_W-1:0] cur_set_id;
        logic            expect_bit;
        int              answered;
        logic            sets_done;
        // Small ID range so reads hit the SET targets
        for (int i = 0; i < N_RAND; i++) begin
            rd_ids[i] = ID_W'($random(seed) & 15);
        end
        for (int k = 0; k < N_SETS; k++) begin
            set_ids[k] = ID_W'($random(seed) & 15);
            gaps[k] = 2 + ($random(seed) & 7);
        end
        answered = 0;
        sets_done = 1'b0;
        cur_set_id = '0;
        fork
            begin
                for (int i = 0; i < N_RAND; i++) begin
                    @(posedge clk);
                    update_req <= 1'b1;
                    update_id <= rd_ids[i];
                    // Hold through update_rdy dips
                    @(negedge clk);
                    while (!update_rdy) @(negedge clk);
                end
                @(posedge clk);
                update_req <= 1'b0;
            end
            begin
                for (int k = 0; k < N_SETS; k++) begin
                    repeat (gaps[k]) @(posedge clk);
                    cur_set_id = set_ids[k];
                    ctrl_req <= 1'b1;
                    ctrl_command <= COMMAND_SET;
                    ctrl_id <= set_ids[k];
                    @(negedge clk);
                    while (!ctrl_rdy) @(negedge clk);
                    @(posedge clk);
                    ctrl_req <= 1'b0;
                    do @(negedge clk); while (!ctrl_ack);
                end
                sets_done = 1'b1;
            end
            begin
                while (answered < N_RAND || !sets_done) begin
                    @(negedge clk);
                    // Model value as of the accept cycle
                    if (update_req && update_rdy) begin
                        pending.push_back(model[update_id]);
                    end
                    if (update_ack) begin
                        assert (pending.size() != 0)
                        else fail_now("update_ack with no read in flight");
                        expect_bit = pending.pop_front();
                        assert (update_state === expect_bit)
                        else fail_now($sformatf("update read %0d returned %b, expected %b",
                                                answered, update_state, expect_bit));
                        answered++;
                    end
                    // SET write lands at the end of its ack cycle
                    if (ctrl_ack) begin
                        assert (ctrl_state === model[cur_set_id])
                        else fail_now($sformatf("SET id %0d old bit %b, expected %b",
                                                cur_set_id, ctrl_state, model[cur_set_id]));
                        model[cur_set_id] = 1'b1;
                    end
                end
            end
        join
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        clear_model();
        reset <= 1'b1;
        ctrl_req <= 1'b0;
        ctrl_command <= '0;
        ctrl_id <= '0;
        update_req <= 1'b0;
        update_id <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!init_done) else fail_now("init_done high before the power-up sweep");
        while (!init_done) @(negedge clk);
        assert (ctrl_rdy && update_rdy) else fail_now("ready low after init_done rose");
        for (int i = 0; i < TABLE_LEN; i++) begin
            apply_step(steps[i]);
        end
        random_burst();
        repeat (4) @(posedge clk);
        if (state_valid_top_inst.state_valid_checker_inst.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1, "checker reported a protocol error");
        end
    end

endmodule : state_valid_tb

// ==== test/state_valid_checker.sv ====
`timescale 1ns/1ns

module state_valid_checker (
    input logic clk,
    input logic reset,
    input logic init_done,
    input logic ctrl_rdy,
    input logic ctrl_ack,
    input logic update_req,
    input logic update_rdy,
    input logic update_ack,
    input logic evt_activate,
    input logic evt_deactivate
);

    // Failed assertions so far, polled by the testbench
    int fail_count = 0;

    // No handshake while the sweep runs
    rdy_during_init: assert property (@(posedge clk) disable iff (reset)
        !init_done |-> (!ctrl_rdy && !update_rdy))
    else begin
        fail_count++;
        $error("ready high while init_done is low");
    end

    // Fixed read pipeline, ack two cycles after acceptance
    update_latency: assert property (@(posedge clk) disable iff (reset)
        update_ack == $past(update_req && update_rdy, 2))
    else begin
        fail_count++;
        $error("update_ack not two cycles after an accepted read");
    end

    evt_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(evt_activate && evt_deactivate))
    else begin
        fail_count++;
        $error("evt_activate and evt_deactivate high together");
    end

    // Port stays busy until the ack
    ack_while_busy: assert property (@(posedge clk) disable iff (reset)
        ctrl_ack |-> !ctrl_rdy)
    else begin
        fail_count++;
        $error("ctrl_ack while ctrl_rdy is high");
    end

endmodule : state_valid_checker

bind state_valid_top state_valid_checker state_valid_checker_inst (
    .clk            (clk),
    .reset          (reset),
    .init_done      (init_done),
    .ctrl_rdy       (ctrl_rdy),
    .ctrl_ack       (ctrl_ack),
    .update_req     (update_req),
    .update_rdy     (update_rdy),
    .update_ack     (update_ack),
    .evt_activate   (evt_activate),
    .evt_deactivate (evt_deactivate)
);

// ==== hw/state_valid_top.sv ====
`timescale 1ns/1ns

module state_valid_top import state_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    output logic             init_done,

    input  logic             ctrl_req,
    input  logic [CMD_W-1:0] ctrl_command,
    input  logic [ID_W-1:0]  ctrl_id,
    output logic             ctrl_rdy,
    output logic             ctrl_ack,
    output logic             ctrl_state,

    input  logic             update_req,
    input  logic [ID_W-1:0]  update_id,
    output logic             update_rdy,
    output logic             update_ack,
    output logic             update_state,

    output logic             evt_activate,
    output logic             evt_deactivate
);

    // Core to storage
    logic            db_init;
    logic            db_init_done;
    logic            db_wr_en;
    logic [ID_W-1:0] db_wr_id;
    logic            db_wr_data;
    logic            db_rd_req;
    logic [ID_W-1:0] db_rd_id;
    logic            db_rd_ack;
    logic            db_rd_data;

    state_valid_core state_valid_core_inst (
        .clk            (clk),
        .reset          (reset),
        .init_done      (init_done),
        .ctrl_req       (ctrl_req),
        .ctrl_command   (ctrl_command),
        .ctrl_id        (ctrl_id),
        .ctrl_rdy       (ctrl_rdy),
        .ctrl_ack       (ctrl_ack),
        .ctrl_state     (ctrl_state),
        .update_req     (update_req),
        .update_id      (update_id),
        .update_rdy     (update_rdy),
        .update_ack     (update_ack),
        .update_state   (update_state),
        .evt_activate   (evt_activate),
        .evt_deactivate (evt_deactivate),
        .db_init        (db_init),
        .db_init_done   (db_init_done),
        .db_wr_en       (db_wr_en),
        .db_wr_id       (db_wr_id),
        .db_wr_data     (db_wr_data),
        .db_rd_req      (db_rd_req),
        .db_rd_id       (db_rd_id),
        .db_rd_ack      (db_rd_ack),
        .db_rd_data     (db_rd_data)
    );

    state_ram state_ram_inst (
        .clk          (clk),
        .reset        (reset),
        .db_init      (db_init),
        .db_init_done (db_init_done),
        .db_wr_en     (db_wr_en),
        .db_wr_id     (db_wr_id),
        .db_wr_data   (db_wr_data),
        .db_rd_req    (db_rd_req),
        .db_rd_id     (db_rd_id),
        .db_rd_ack    (db_rd_ack),
        .db_rd_data   (db_rd_data)
    );

endmodule : state_valid_top

// ==== hw/state_valid_core.sv ====
`timescale 1ns/1ns

module state_valid_core import state_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    output logic             init_done,

    // Control port
    input  logic             ctrl_req,
    input  logic [CMD_W-1:0] ctrl_command,
    input  logic [ID_W-1:0]  ctrl_id,
    output logic             ctrl_rdy,
    output logic             ctrl_ack,
    output logic             ctrl_state,

    // Update port, read only
    input  logic             update_req,
    input  logic [ID_W-1:0]  update_id,
    output logic             update_rdy,
    output logic             update_ack,
    output logic             update_state,

    // Status events
    output logic             evt_activate,
    output logic             evt_deactivate,

    // Storage
    output logic             db_init,
    input  logic             db_init_done,
    output logic             db_wr_en,
    output logic [ID_W-1:0]  db_wr_id,
    output logic             db_wr_data,
    output logic             db_rd_req,
    output logic [ID_W-1:0]  db_rd_id,
    input  logic             db_rd_ack,
    input  logic             db_rd_data
);

    logic ctrl_accept;

    // Generic engine, the update port rides on its app read path
    db_core db_core_inst (
        .clk          (clk),
        .reset        (reset),
        .ctrl_req     (ctrl_req),
        .ctrl_command (ctrl_command),
        .ctrl_id      (ctrl_id),
        .ctrl_rdy     (ctrl_rdy),
        .ctrl_ack     (ctrl_ack),
        .ctrl_state   (ctrl_state),
        .app_rd_req   (update_req),
        .app_rd_id    (update_id),
        .app_rd_rdy   (update_rdy),
        .app_rd_ack   (update_ack),
        .app_rd_data  (update_state),
        .init_done    (init_done),
        .db_init      (db_init),
        .db_init_done (db_init_done),
        .db_wr_en     (db_wr_en),
        .db_wr_id     (db_wr_id),
        .db_wr_data   (db_wr_data),
        .db_rd_req    (db_rd_req),
        .db_rd_id     (db_rd_id),
        .db_rd_ack    (db_rd_ack),
        .db_rd_data   (db_rd_data)
    );

    // ------------------------------------------------------------
    // Status events, one cycle after acceptance
    // ------------------------------------------------------------

    assign ctrl_accept = ctrl_req && ctrl_rdy;

    always_ff @(posedge clk) begin
        if (reset) begin
            evt_activate <= 1'b0;
            evt_deactivate <= 1'b0;
        end else begin
            evt_activate <= ctrl_accept && (ctrl_command == COMMAND_SET);
            evt_deactivate <= ctrl_accept && (ctrl_command == COMMAND_UNSET);
        end
    end

endmodule : state_valid_core

// ==== hw/state_ram.sv ====
`timescale 1ns/1ns

module state_ram import state_pkg::*; (
    input  logic            clk,
    input  logic            reset,

    // Zero sweep
    input  logic            db_init,
    output logic            db_init_done,

    // Write port, one cycle, no handshake
    input  logic            db_wr_en,
    input  logic [ID_W-1:0] db_wr_id,
    input  logic            db_wr_data,

    // Pipelined read port
    input  logic            db_rd_req,
    input  logic [ID_W-1:0] db_rd_id,
    output logic            db_rd_ack,
    output logic            db_rd_data
);

    logic [NUM_IDS-1:0] mem;
    logic               sweeping;
    logic [ID_W-1:0]    sweep_idx;
    // Read stages, 1 then 2
    logic               rd_vld_1;
    logic               rd_data_1;
    logic               rd_vld_2;
    logic               rd_data_2;

    // ------------------------------------------------------------
    // Sweep control
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            sweeping <= 1'b0;
            sweep_idx <= '0;
            db_init_done <= 1'b0;
        end else if (db_init) begin
            sweeping <= 1'b1;
            sweep_idx <= '0;
            db_init_done <= 1'b0;
        end else if (sweeping) begin
            sweep_idx <= sweep_idx + 1'b1;
            // Last entry cleared this cycle
            if (sweep_idx == ID_W'(NUM_IDS - 1)) begin
                sweeping <= 1'b0;
                db_init_done <= 1'b1;
            end
        end
    end

    // Storage, the sweep owns the write port while running
    always_ff @(posedge clk) begin
        if (sweeping) begin
            mem[sweep_idx] <= 1'b0;
        end else if (db_wr_en) begin
            mem[db_wr_id] <= db_wr_data;
        end
    end

    // ------------------------------------------------------------
    // Read pipeline
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_vld_1 <= 1'b0;
            rd_vld_2 <= 1'b0;
        end else begin
            rd_vld_1 <= db_rd_req;
            rd_vld_2 <= rd_vld_1;
        end
    end

    // Same-cycle write is not visible here
    always_ff @(posedge clk) begin
        rd_data_1 <= mem[db_rd_id];
        rd_data_2 <= rd_data_1;
    end

    assign db_rd_ack = rd_vld_2;
    assign db_rd_data = rd_data_2;

endmodule : state_ram

// ==== db_core/db_core.sv ====
`timescale 1ns/1ns

module db_core import state_pkg::*; (
    input  logic             clk,
    input  logic             reset,

    // Control requester
    input  logic             ctrl_req,
    input  logic [CMD_W-1:0] ctrl_command,
    input  logic [ID_W-1:0]  ctrl_id,
    output logic             ctrl_rdy,
    output logic             ctrl_ack,
    output logic             ctrl_state,

    // Application read requester
    input  logic             app_rd_req,
    input  logic [ID_W-1:0]  app_rd_id,
    output logic             app_rd_rdy,
    output logic             app_rd_ack,
    output logic             app_rd_data,

    output logic             init_done,

    // Storage side
    output logic             db_init,
    input  logic             db_init_done,
    output logic             db_wr_en,
    output logic [ID_W-1:0]  db_wr_id,
    output logic             db_wr_data,
    output logic             db_rd_req,
    output logic [ID_W-1:0]  db_rd_id,
    input  logic             db_rd_ack,
    input  logic             db_rd_data
);

    logic [ST_W-1:0]       state;
    // Set once db_init has gone out for the current sweep
    logic                  init_wait;
    logic [CMD_W-1:0]      cmd_q;
    logic [ID_W-1:0]       id_q;
    logic                  old_q;
    // One bit per read in flight, high for control reads
    logic [RD_LATENCY-1:0] tag_sr;
    logic                  ctrl_accept;
    logic                  ctrl_rd_issue;
    logic                  ctrl_rd_ack;
    logic                  sweep_end;

    // ------------------------------------------------------------
    // Handshakes and read arbitration
    // ------------------------------------------------------------

    // Single-threaded control port
    assign ctrl_rdy = (state == ST_IDLE);
    assign ctrl_accept = ctrl_req && ctrl_rdy;

    // Old bit read goes out in the accept cycle, CLEAR needs none
    assign ctrl_rd_issue = ctrl_accept && (ctrl_command != COMMAND_CLEAR);

    // Control read takes the port, app waits
    assign app_rd_rdy = init_done && !ctrl_rd_issue;

    assign db_rd_req = ctrl_rd_issue || (app_rd_req && app_rd_rdy);
    assign db_rd_id = ctrl_rd_issue ? ctrl_id : app_rd_id;

    // Steer returning data by the tag at the end of the pipe
    assign ctrl_rd_ack = db_rd_ack && tag_sr[RD_LATENCY-1];
    assign app_rd_ack = db_rd_ack && !tag_sr[RD_LATENCY-1];
    assign app_rd_data = db_rd_data;

    // ------------------------------------------------------------
    // Sweep and write side
    // ------------------------------------------------------------

    assign db_init = ((state == ST_INIT) || (state == ST_CLEAR)) && !init_wait;
    assign sweep_end = init_wait && db_init_done;
    assign init_done = (state != ST_INIT) && (state != ST_CLEAR);

    // Write lands together with the ack
    assign db_wr_en = (state == ST_WRITE);
    assign db_wr_id = id_q;
    assign db_wr_data = (cmd_q == COMMAND_SET);

    assign ctrl_ack = (state == ST_WRITE)
                    || ((state == ST_READ) && ctrl_rd_ack && (cmd_q == COMMAND_GET))
                    || ((state == ST_CLEAR) && sweep_end);

    // GET gives the stored bit, SET/UNSET the bit before
    always_comb begin
        case (state)
            ST_READ:  ctrl_state = db_rd_data;
            ST_WRITE: ctrl_state = old_q;
            default:  ctrl_state = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_INIT;
            init_wait <= 1'b0;
            tag_sr <= '0;
        end else begin
            tag_sr <= {tag_sr[RD_LATENCY-2:0], ctrl_rd_issue};
            case (state)
                ST_INIT, ST_CLEAR: begin
                    // db_init falls once the flag is set
                    if (!init_wait) begin
                        init_wait <= 1'b1;
                    end else if (db_init_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (ctrl_accept) begin
                        if (ctrl_command == COMMAND_CLEAR) begin
                            state <= ST_CLEAR;
                            init_wait <= 1'b0;
                        end else begin
                            state <= ST_READ;
                        end
                    end
                end
                ST_READ: begin
                    if (ctrl_rd_ack) begin
                        state <= (cmd_q == COMMAND_GET) ? ST_IDLE : ST_WRITE;
                    end
                end
                ST_WRITE: state <= ST_IDLE;
                default:  state <= ST_INIT;
            endcase
        end
    end

    // Command fields and the old bit
    always_ff @(posedge clk) begin
        if (ctrl_accept) begin
            cmd_q <= ctrl_command;
            id_q <= ctrl_id;
        end
        if (ctrl_rd_ack) begin
            old_q <= db_rd_data;
        end
    end

endmodule : db_core

// ==== common/state_pkg.sv ====
package state_pkg;

    // ------------------------------------------------------------
    // Table geometry
    // ------------------------------------------------------------

    // One ID word addresses one valid bit
    localparam int ID_W = 8;
    localparam int NUM_IDS = 2 ** ID_W;

    // Storage read pipeline depth, request to data
    localparam int RD_LATENCY = 2;

    // ------------------------------------------------------------
    // Control command encoding
    // ------------------------------------------------------------

    localparam int CMD_W = 2;

    localparam logic [CMD_W-1:0] COMMAND_SET = 2'd0;
    localparam logic [CMD_W-1:0] COMMAND_UNSET = 2'd1;
    localparam logic [CMD_W-1:0] COMMAND_GET = 2'd2;
    // Wipes the whole table, acked after the sweep
    localparam logic [CMD_W-1:0] COMMAND_CLEAR = 2'd3;

    // ------------------------------------------------------------
    // Engine FSM encoding
    // ------------------------------------------------------------

    localparam int ST_W = 3;

    // Power-up sweep, no ack
    localparam logic [ST_W-1:0] ST_INIT = 3'd0;
    localparam logic [ST_W-1:0] ST_IDLE = 3'd1;
    // Waiting on the old bit
    localparam logic [ST_W-1:0] ST_READ = 3'd2;
    localparam logic [ST_W-1:0] ST_WRITE = 3'd3;
    // Sweep on request, acked at the end
    localparam logic [ST_W-1:0] ST_CLEAR = 3'd4;

endpackage : state_pkg
